//--- logic/cap_sram_pkg.sv
/*
 * Tagged SRAM shared definitions.
 * Bus and word widths, address offsets and the queued response entry.
 */
package cap_sram_pkg;

  // Low byte-address bits that select a byte inside one data word.
  function automatic int unsigned word_off(int unsigned dw);
    return $clog2(dw / 8);
  endfunction

  // Word-address bits dropped so that one tag bit covers 64 data bits.
  function automatic int unsigned tag_shift(int unsigned dw);
    return 3 - word_off(dw);
  endfunction

  // Byte address width on each bus.
  localparam int unsigned AddrWidth    = 12;
  // Data word width, at most 64 so a word never spans two tags.
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BytesPerWord = DataWidth / 8;
  localparam int unsigned WordOff      = word_off(DataWidth);
  // Word address width seen by the storage.
  localparam int unsigned WordAw       = AddrWidth - WordOff;
  // 1 for 32-bit words, 0 for 64-bit words.
  localparam int unsigned TagShift     = tag_shift(DataWidth);
  // Entries in each adapter's response queue.
  localparam int unsigned RspDepth     = 2;

  // One response waiting in an adapter queue.
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 rcap;
    // Write sent to a read-only port.
    logic                 err;
    // Entry answers a write, so it carries no read data.
    logic                 wack;
  } rsp_t;

endpackage

//--- logic/mem_port_if.sv
/*
 * Memory port between a bus adapter and the tagged storage.
 * Requests are granted at once, reads return one cycle later.
 */
`timescale 1ns/1ps

interface mem_port_if import cap_sram_pkg::*; #(
  parameter int unsigned WordAw    = cap_sram_pkg::WordAw,
  parameter int unsigned DataWidth = cap_sram_pkg::DataWidth
);

  // Request side, driven by the adapter.
  logic                   req;
  logic                   we;
  // Address in words, byte offset already removed.
  logic [WordAw-1:0]      addr;
  logic [DataWidth-1:0]   wdata;
  logic [DataWidth/8-1:0] be;
  logic                   wcap;

  // Response side, driven by the storage.
  logic                   rvalid;
  logic [DataWidth-1:0]   rdata;
  logic                   rcap;

  modport adapter (
    output req, we, addr, wdata, be, wcap,
    input  rvalid, rdata, rcap
  );

  modport mem (
    input  req, we, addr, wdata, be, wcap,
    output rvalid, rdata, rcap
  );

endinterface

//--- logic/bus_sram_adapter.sv
/*
 * Bus to SRAM adapter.
 * Turns valid/ready requests into single-cycle accesses, answers in order.
 */
`timescale 1ns/1ps

module bus_sram_adapter import cap_sram_pkg::*; #(
  parameter int unsigned AddrWidth = cap_sram_pkg::AddrWidth,
  parameter int unsigned DataWidth = cap_sram_pkg::DataWidth,
  parameter int unsigned RspDepth  = cap_sram_pkg::RspDepth,
  parameter bit          ReadOnly  = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_write_i,
  input  logic [AddrWidth-1:0]   req_addr_i,
  input  logic [DataWidth-1:0]   req_wdata_i,
  input  logic [DataWidth/8-1:0] req_be_i,
  input  logic                   req_wcap_i,

  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [DataWidth-1:0]   rsp_rdata_o,
  output logic                   rsp_rcap_o,
  output logic                   rsp_err_o,

  mem_port_if.adapter            mem
);

  localparam int unsigned ByteOff = word_off(DataWidth);
  localparam int unsigned CntW    = $clog2(RspDepth + 1);
  localparam int unsigned PtrW    = (RspDepth > 1) ? $clog2(RspDepth) : 1;

  logic            req_acc;
  logic            rsp_pop;
  logic            wr_reject;
  logic [CntW-1:0] credits_q;

  // Kind of the request accepted in the previous cycle.
  logic            pend_wr_q;
  logic            pend_err_q;

  logic            fifo_push;
  rsp_t            rsp_push;
  rsp_t            fifo_q [RspDepth];
  rsp_t            fifo_head;
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] fifo_cnt_q;

  // A response leaving the queue frees its credit in the same cycle.
  assign rsp_pop     = rsp_valid_o & rsp_ready_i;
  assign req_ready_o = (credits_q != '0) | rsp_pop;
  assign req_acc     = req_valid_i & req_ready_o;

  // Writes to a read-only port never reach the storage.
  assign wr_reject = ReadOnly & req_write_i;

  assign mem.req   = req_acc & ~wr_reject;
  assign mem.we    = req_write_i & ~ReadOnly;
  assign mem.addr  = req_addr_i[AddrWidth-1:ByteOff];
  assign mem.wdata = ReadOnly ? '0 : req_wdata_i;
  assign mem.be    = ReadOnly ? '0 : req_be_i;
  assign mem.wcap  = req_wcap_i & ~ReadOnly;

  // Read data arrives with rvalid, writes are answered from the kind register.
  assign fifo_push = mem.rvalid | pend_wr_q;

  always_comb begin
    rsp_push.rdata = mem.rdata;
    rsp_push.rcap  = mem.rcap;
    rsp_push.err   = pend_err_q;
    rsp_push.wack  = pend_wr_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q  <= CntW'(RspDepth);
      pend_wr_q  <= 1'b0;
      pend_err_q <= 1'b0;
    end else begin
      credits_q  <= credits_q - CntW'(req_acc) + CntW'(rsp_pop);
      pend_wr_q  <= req_acc & req_write_i;
      pend_err_q <= req_acc & wr_reject;
    end
  end

  // Response queue pointers and fill level.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (fifo_push) begin
        wptr_q <= (wptr_q == PtrW'(RspDepth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (rsp_pop) begin
        rptr_q <= (rptr_q == PtrW'(RspDepth - 1)) ? '0 : rptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + CntW'(fifo_push) - CntW'(rsp_pop);
    end
  end

  // Queue storage.
  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_q[wptr_q] <= rsp_push;
    end
  end

  assign fifo_head   = fifo_q[rptr_q];
  assign rsp_valid_o = (fifo_cnt_q != '0);
  // Write answers return zero data and tag.
  assign rsp_rdata_o = fifo_head.wack ? '0 : fifo_head.rdata;
  assign rsp_rcap_o  = fifo_head.rcap & ~fifo_head.wack;
  assign rsp_err_o   = fifo_head.err;

endmodule

//--- logic/cap_mem.sv
/*
 * Tagged storage: data array with byte writes and one tag per 64 bits.
 * Port A reads and writes, port B only reads.
 */
`timescale 1ns/1ps

module cap_mem import cap_sram_pkg::*; #(
  parameter int unsigned WordAw    = cap_sram_pkg::WordAw,
  parameter int unsigned DataWidth = cap_sram_pkg::DataWidth,
  parameter int unsigned TagShift  = cap_sram_pkg::TagShift
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  mem_port_if.mem port_a,
  mem_port_if.mem port_b
);

  localparam int unsigned NumWords = 2 ** WordAw;
  localparam int unsigned NumTags  = NumWords >> TagShift;
  localparam int unsigned TagAw    = WordAw - TagShift;
  localparam int unsigned NumBytes = DataWidth / 8;

  logic [DataWidth-1:0] data_mem [NumWords];
  logic                 tag_mem  [NumTags];

  // Tag index is the word address without its group bits.
  logic [TagAw-1:0]     tag_a_idx;
  logic [TagAw-1:0]     tag_b_idx;

  assign tag_a_idx = port_a.addr[WordAw-1:TagShift];
  assign tag_b_idx = port_b.addr[WordAw-1:TagShift];

  // Port A write. Any write replaces the group tag with wcap.
  always_ff @(posedge clk_i) begin
    if (port_a.req && port_a.we) begin
      for (int i = 0; i < NumBytes; i++) begin
        if (port_a.be[i]) begin
          data_mem[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
        end
      end
      tag_mem[tag_a_idx] <= port_a.wcap;
    end
  end

  // Registered reads.
  always_ff @(posedge clk_i) begin
    if (port_a.req && !port_a.we) begin
      port_a.rdata <= data_mem[port_a.addr];
      port_a.rcap  <= tag_mem[tag_a_idx];
    end
    if (port_b.req) begin
      port_b.rdata <= data_mem[port_b.addr];
      port_b.rcap  <= tag_mem[tag_b_idx];
    end
  end

  // Read valid follows each read request by one cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      port_a.rvalid <= 1'b0;
      port_b.rvalid <= 1'b0;
    end else begin
      port_a.rvalid <= port_a.req & ~port_a.we;
      port_b.rvalid <= port_b.req;
    end
  end

endmodule

//--- logic/cap_sram.sv
/*
 * Dual-port capability-tagged SRAM.
 * Port A is a data port, port B an instruction-fetch port.
 */
`timescale 1ns/1ps

module cap_sram import cap_sram_pkg::*; #(
  parameter int unsigned AddrWidth = cap_sram_pkg::AddrWidth,
  parameter int unsigned DataWidth = cap_sram_pkg::DataWidth,
  parameter int unsigned RspDepth  = cap_sram_pkg::RspDepth
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Port A is the read/write data bus.
  input  logic                   a_req_valid_i,
  output logic                   a_req_ready_o,
  input  logic                   a_req_write_i,
  input  logic [AddrWidth-1:0]   a_req_addr_i,
  input  logic [DataWidth-1:0]   a_req_wdata_i,
  input  logic [DataWidth/8-1:0] a_req_be_i,
  input  logic                   a_req_wcap_i,
  output logic                   a_rsp_valid_o,
  input  logic                   a_rsp_ready_i,
  output logic [DataWidth-1:0]   a_rsp_rdata_o,
  output logic                   a_rsp_rcap_o,
  output logic                   a_rsp_err_o,

  // Port B is the fetch bus. Writes are answered with an error.
  input  logic                   b_req_valid_i,
  output logic                   b_req_ready_o,
  input  logic                   b_req_write_i,
  input  logic [AddrWidth-1:0]   b_req_addr_i,
  output logic                   b_rsp_valid_o,
  input  logic                   b_rsp_ready_i,
  output logic [DataWidth-1:0]   b_rsp_rdata_o,
  output logic                   b_rsp_rcap_o,
  output logic                   b_rsp_err_o
);

  // Word address width and tag grouping for the storage.
  localparam int unsigned MemAw  = AddrWidth - word_off(DataWidth);
  localparam int unsigned TagOff = tag_shift(DataWidth);

  mem_port_if #(.WordAw(MemAw), .DataWidth(DataWidth)) mem_a ();
  mem_port_if #(.WordAw(MemAw), .DataWidth(DataWidth)) mem_b ();

  bus_sram_adapter #(
    .AddrWidth ( AddrWidth ),
    .DataWidth ( DataWidth ),
    .RspDepth  ( RspDepth  ),
    .ReadOnly  ( 1'b0      )
  ) u_adapter_a (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_valid_i ( a_req_valid_i ),
    .req_ready_o ( a_req_ready_o ),
    .req_write_i ( a_req_write_i ),
    .req_addr_i  ( a_req_addr_i  ),
    .req_wdata_i ( a_req_wdata_i ),
    .req_be_i    ( a_req_be_i    ),
    .req_wcap_i  ( a_req_wcap_i  ),
    .rsp_valid_o ( a_rsp_valid_o ),
    .rsp_ready_i ( a_rsp_ready_i ),
    .rsp_rdata_o ( a_rsp_rdata_o ),
    .rsp_rcap_o  ( a_rsp_rcap_o  ),
    .rsp_err_o   ( a_rsp_err_o   ),
    .mem         ( mem_a         )
  );

  // Fetch side has no write payload.
  bus_sram_adapter #(
    .AddrWidth ( AddrWidth ),
    .DataWidth ( DataWidth ),
    .RspDepth  ( RspDepth  ),
    .ReadOnly  ( 1'b1      )
  ) u_adapter_b (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_valid_i ( b_req_valid_i ),
    .req_ready_o ( b_req_ready_o ),
    .req_write_i ( b_req_write_i ),
    .req_addr_i  ( b_req_addr_i  ),
    .req_wdata_i (               ),
    .req_be_i    (               ),
    .req_wcap_i  (               ),
    .rsp_valid_o ( b_rsp_valid_o ),
    .rsp_ready_i ( b_rsp_ready_i ),
    .rsp_rdata_o ( b_rsp_rdata_o ),
    .rsp_rcap_o  ( b_rsp_rcap_o  ),
    .rsp_err_o   ( b_rsp_err_o   ),
    .mem         ( mem_b         )
  );

  cap_mem #(
    .WordAw    ( MemAw     ),
    .DataWidth ( DataWidth ),
    .TagShift  ( TagOff    )
  ) u_mem (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .port_a ( mem_a  ),
    .port_b ( mem_b  )
  );

endmodule

//--- dv/cap_sram_checker.sv
/*
 * Handshake and ordering assertions for the tagged SRAM, bound into the top level.
 */
`timescale 1ns/1ps

module cap_sram_checker import cap_sram_pkg::*; #(
  parameter int unsigned AddrWidth = cap_sram_pkg::AddrWidth,
  parameter int unsigned DataWidth = cap_sram_pkg::DataWidth,
  parameter int unsigned RspDepth  = cap_sram_pkg::RspDepth
) (
  input logic                                     clk_i,
  input logic                                     rst_ni,
  input logic                                     a_valid_i,
  input logic                                     a_ready_i,
  // Write flag, address, data, byte enables and capability flag.
  input logic [AddrWidth+DataWidth+DataWidth/8+1:0] a_fields_i,
  input logic                                     a_rsp_valid_i,
  input logic                                     a_rsp_ready_i,
  input logic                                     b_valid_i,
  input logic                                     b_ready_i,
  input logic [AddrWidth:0]                       b_fields_i,
  input logic                                     b_rsp_valid_i,
  input logic                                     b_rsp_ready_i,
  input logic                                     a_mem_rd_i,
  input logic                                     a_mem_rvalid_i,
  input logic                                     b_mem_rd_i,
  input logic                                     b_mem_rvalid_i
);

  // Requests accepted minus responses taken, per port.
  int unsigned a_open_q;
  int unsigned b_open_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_open_q <= 0;
      b_open_q <= 0;
    end else begin
      a_open_q <= a_open_q + 32'(a_valid_i & a_ready_i) - 32'(a_rsp_valid_i & a_rsp_ready_i);
      b_open_q <= b_open_q + 32'(b_valid_i & b_ready_i) - 32'(b_rsp_valid_i & b_rsp_ready_i);
    end
  end

  // A stalled request keeps its fields.
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_valid_i && !a_ready_i |=> a_valid_i && $stable(a_fields_i))
    else $error("Port A request changed while stalled");
  b_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_fields_i))
    else $error("Port B request changed while stalled");

  // Never more requests in flight than queue entries.
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_open_q <= RspDepth)
    else $error("Port A has more requests in flight than credits");
  b_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_open_q <= RspDepth)
    else $error("Port B has more requests in flight than credits");

  // Storage answers each read one cycle later.
  a_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_mem_rd_i |=> a_mem_rvalid_i)
    else $error("Port A storage read without rvalid one cycle later");
  b_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_mem_rd_i |=> b_mem_rvalid_i)
    else $error("Port B storage read without rvalid one cycle later");

endmodule

//--- dv/tb_cap_sram_tasks.svh
/*
 * Request, response-wait and compare tasks for the tagged SRAM testbench.
 */

// Prints the reason, then the fail message, and stops.
task automatic fail_run(input string why);
  $display("%s", why);
  $display("SIMULATION FAILED");
  $fatal(1, "Stopping at first error");
endtask

task automatic check_word(input string name, input logic [DataWidth-1:0] got,
                          input logic [DataWidth-1:0] exp);
  assert (got === exp)
    else fail_run($sformatf("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  assert (got === exp)
    else fail_run($sformatf("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp));
endtask

function automatic logic [DataWidth-1:0] rand_word();
  logic [63:0] r;
  r = {$random(seed), $random(seed)};
  return r[DataWidth-1:0];
endfunction

function automatic logic [BytesPerWord-1:0] rand_be();
  logic [31:0] r;
  r = $random(seed);
  return r[BytesPerWord-1:0];
endfunction

function automatic logic [AddrWidth-1:0] byte_addr(input int unsigned word);
  return AddrWidth'(word * BytesPerWord);
endfunction

// Model update at acceptance; a write replaces the whole group tag.
task automatic record_a();
  logic [WordAw-1:0] word;
  rsp_t              exp;
  word = a_req_addr_i[AddrWidth-1:WordOff];
  exp  = '0;
  if (a_req_write_i) begin
    for (int i = 0; i < BytesPerWord; i++) begin
      if (a_req_be_i[i]) begin
        ref_mem[word][8*i +: 8] = a_req_wdata_i[8*i +: 8];
      end
    end
    ref_tag[a_req_addr_i[AddrWidth-1:3]] = a_req_wcap_i;
    exp.wack = 1'b1;
  end else begin
    exp.rdata = ref_mem[word];
    exp.rcap  = ref_tag[a_req_addr_i[AddrWidth-1:3]];
  end
  exp_a.push_back(exp);
endtask

// Fetch port writes leave the model untouched and expect an error.
task automatic record_b();
  logic [WordAw-1:0] word;
  rsp_t              exp;
  word = b_req_addr_i[AddrWidth-1:WordOff];
  exp  = '0;
  if (b_req_write_i) begin
    exp.err  = 1'b1;
    exp.wack = 1'b1;
  end else begin
    exp.rdata = ref_mem[word];
    exp.rcap  = ref_tag[b_req_addr_i[AddrWidth-1:3]];
  end
  exp_b.push_back(exp);
endtask

task automatic compare_rsp(input string port, input rsp_t exp, input logic [DataWidth-1:0] data,
                           input logic cap, input logic err);
  check_bit({port, "_rsp_err_o"}, err, exp.err);
  // Write answers carry no read data.
  if (!exp.wack) begin
    check_word({port, "_rsp_rdata_o"}, data, exp.rdata);
    check_bit({port, "_rsp_rcap_o"}, cap, exp.rcap);
  end
endtask

task automatic drive_req(input bit a_en, input bit a_wr, input int unsigned a_word,
                         input logic [DataWidth-1:0] a_data,
                         input logic [BytesPerWord-1:0] a_be, input bit a_cap,
                         input bit b_en, input bit b_wr, input int unsigned b_word);
  @(negedge clk_i);
  a_req_valid_i = a_en;
  a_req_write_i = a_wr;
  a_req_addr_i  = byte_addr(a_word);
  a_req_wdata_i = a_data;
  a_req_be_i    = a_be;
  a_req_wcap_i  = a_cap;
  b_req_valid_i = b_en;
  b_req_write_i = b_wr;
  b_req_addr_i  = byte_addr(b_word);
endtask

// Holds each request until accepted, drops a port once it is done.
task automatic wait_accept(input bit a_pend, input bit b_pend);
  int unsigned waited;
  waited = 0;
  while (a_pend || b_pend) begin
    assert (waited < Timeout) else fail_run("Request was not accepted before the timeout");
    @(posedge clk_i);
    waited++;
    if (a_pend && a_req_ready_o) begin
      record_a();
      a_pend = 1'b0;
    end
    if (b_pend && b_req_ready_o) begin
      record_b();
      b_pend = 1'b0;
    end
    if (a_pend || b_pend) begin
      @(negedge clk_i);
      a_req_valid_i = a_pend;
      b_req_valid_i = b_pend;
    end
  end
endtask

task automatic issue(input bit a_en, input bit a_wr, input int unsigned a_word,
                     input logic [DataWidth-1:0] a_data, input logic [BytesPerWord-1:0] a_be,
                     input bit a_cap, input bit b_en, input bit b_wr, input int unsigned b_word);
  drive_req(a_en, a_wr, a_word, a_data, a_be, a_cap, b_en, b_wr, b_word);
  wait_accept(a_en, b_en);
endtask

task automatic write_a(input int unsigned word, input logic [DataWidth-1:0] data,
                       input logic [BytesPerWord-1:0] be, input bit cap);
  issue(1'b1, 1'b1, word, data, be, cap, 1'b0, 1'b0, 0);
endtask

task automatic read_a(input int unsigned word);
  issue(1'b1, 1'b0, word, '0, '0, 1'b0, 1'b0, 1'b0, 0);
endtask

// Same word on both ports in one cycle.
task automatic read_ab(input int unsigned word);
  issue(1'b1, 1'b0, word, '0, '0, 1'b0, 1'b1, 1'b0, word);
endtask

// Drops both requests and waits until every response has come back.
task automatic wait_responses();
  int unsigned waited;
  @(negedge clk_i);
  a_req_valid_i = 1'b0;
  b_req_valid_i = 1'b0;
  waited = 0;
  while (exp_a.size() != 0 || exp_b.size() != 0) begin
    assert (waited < Timeout) else fail_run("Responses did not arrive before the timeout");
    @(negedge clk_i);
    waited++;
  end
endtask

//--- dv/tb_cap_sram.sv
/*
 * Testbench for the dual-port capability-tagged SRAM.
 * Directed and random traffic checked against a word and tag model.
 */
`timescale 1ns/1ps

module tb_cap_sram import cap_sram_pkg::*; ();

  localparam int unsigned Timeout     = 200;
  // Word region used by the random traffic.
  localparam int unsigned RegionBase  = 192;
  localparam int unsigned RegionWords = 32;
  localparam int unsigned RandOps     = 200;

  integer seed = 26866;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    a_req_valid_i;
  logic                    a_req_ready_o;
  logic                    a_req_write_i;
  logic [AddrWidth-1:0]    a_req_addr_i;
  logic [DataWidth-1:0]    a_req_wdata_i;
  logic [BytesPerWord-1:0] a_req_be_i;
  logic                    a_req_wcap_i;
  logic                    a_rsp_valid_o;
  logic                    a_rsp_ready_i;
  logic [DataWidth-1:0]    a_rsp_rdata_o;
  logic                    a_rsp_rcap_o;
  logic                    a_rsp_err_o;
  logic                    b_req_valid_i;
  logic                    b_req_ready_o;
  logic                    b_req_write_i;
  logic [AddrWidth-1:0]    b_req_addr_i;
  logic                    b_rsp_valid_o;
  logic                    b_rsp_ready_i;
  logic [DataWidth-1:0]    b_rsp_rdata_o;
  logic                    b_rsp_rcap_o;
  logic                    b_rsp_err_o;

  // Reference model and expected responses per port.
  logic [DataWidth-1:0] ref_mem [2**WordAw];
  // One tag per 64-bit group, indexed by the byte address without its low 3 bits.
  logic                 ref_tag [2**(AddrWidth-3)];
  rsp_t                 exp_a [$];
  rsp_t                 exp_b [$];

  cap_sram cap_sram_i (.*);

  bind cap_sram cap_sram_checker #(
    .AddrWidth ( AddrWidth ),
    .DataWidth ( DataWidth ),
    .RspDepth  ( RspDepth  )
  ) u_cap_sram_checker (
    .clk_i          ( clk_i                                                           ),
    .rst_ni         ( rst_ni                                                          ),
    .a_valid_i      ( a_req_valid_i                                                   ),
    .a_ready_i      ( a_req_ready_o                                                   ),
    .a_fields_i     ( {a_req_write_i, a_req_addr_i, a_req_wdata_i, a_req_be_i, a_req_wcap_i} ),
    .a_rsp_valid_i  ( a_rsp_valid_o                                                   ),
    .a_rsp_ready_i  ( a_rsp_ready_i                                                   ),
    .b_valid_i      ( b_req_valid_i                                                   ),
    .b_ready_i      ( b_req_ready_o                                                   ),
    .b_fields_i     ( {b_req_write_i, b_req_addr_i}                                   ),
    .b_rsp_valid_i  ( b_rsp_valid_o                                                   ),
    .b_rsp_ready_i  ( b_rsp_ready_i                                                   ),
    .a_mem_rd_i     ( mem_a.req & ~mem_a.we                                           ),
    .a_mem_rvalid_i ( mem_a.rvalid                                                    ),
    .b_mem_rd_i     ( mem_b.req & ~mem_b.we                                           ),
    .b_mem_rvalid_i ( mem_b.rvalid                                                    )
  );

  `include "tb_cap_sram_tasks.svh"

  always #4 clk_i = ~clk_i;

  // Each monitor checks one port's responses in request order.
  always @(posedge clk_i) begin : monitor_a
    if (rst_ni && a_rsp_valid_o && a_rsp_ready_i) begin
      assert (exp_a.size() != 0) else fail_run("Port A answered with no request outstanding");
      compare_rsp("a", exp_a.pop_front(), a_rsp_rdata_o, a_rsp_rcap_o, a_rsp_err_o);
    end
  end

  always @(posedge clk_i) begin : monitor_b
    if (rst_ni && b_rsp_valid_o && b_rsp_ready_i) begin
      assert (exp_b.size() != 0) else fail_run("Port B answered with no request outstanding");
      compare_rsp("b", exp_b.pop_front(), b_rsp_rdata_o, b_rsp_rcap_o, b_rsp_err_o);
    end
  end

  task automatic test_reset_state();
    check_bit("a_rsp_valid_o", a_rsp_valid_o, 1'b0);
    check_bit("b_rsp_valid_o", b_rsp_valid_o, 1'b0);
    check_bit("a_req_ready_o", a_req_ready_o, 1'b1);
    check_bit("b_req_ready_o", b_req_ready_o, 1'b1);
  endtask

  // Full word first, then two partial merges per word.
  task automatic test_byte_writes();
    for (int i = 0; i < 4; i++) begin
      write_a(16 + i, rand_word(), '1, 1'b0);
      write_a(16 + i, rand_word(), rand_be(), 1'b0);
      write_a(16 + i, rand_word(), rand_be(), 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      read_ab(16 + i);
    end
    wait_responses();
  endtask

  // Words 64 and 65 share one tag.
  task automatic test_cap_tags();
    write_a(64, rand_word(), '1, 1'b0);
    write_a(65, rand_word(), '1, 1'b0);
    write_a(64, rand_word(), '1, 1'b1);
    read_ab(64);
    read_ab(65);
    write_a(65, rand_word(), '1, 1'b0);
    read_ab(64);
    read_ab(65);
    wait_responses();
  endtask

  task automatic test_fetch_write();
    issue(1'b0, 1'b0, 0, '0, '0, 1'b0, 1'b1, 1'b1, 16);
    read_a(16);
    wait_responses();
  endtask

  task automatic test_backpressure();
    @(negedge clk_i);
    a_rsp_ready_i = 1'b0;
    for (int i = 0; i < RspDepth; i++) begin
      read_a(16 + i);
    end
    // One more read must now stall.
    drive_req(1'b1, 1'b0, 16 + RspDepth, '0, '0, 1'b0, 1'b0, 1'b0, 0);
    repeat (4) begin
      @(posedge clk_i);
      check_bit("a_req_ready_o", a_req_ready_o, 1'b0);
    end
    @(negedge clk_i);
    a_rsp_ready_i = 1'b1;
    wait_accept(1'b1, 1'b0);
    wait_responses();
  endtask

  // Port B always targets a different 64-bit group than port A.
  task automatic test_random_traffic();
    logic [31:0] r;
    logic [4:0]  a_off;
    logic [4:0]  b_off;
    logic [3:0]  nz;
    for (int w = 0; w < RegionWords; w++) begin
      r = $random(seed);
      write_a(RegionBase + w, rand_word(), '1, r[0]);
    end
    for (int n = 0; n < RandOps; n++) begin
      r     = $random(seed);
      a_off = r[4:0];
      nz    = r[8:5];
      if (nz == 4'd0) begin
        nz = 4'd1;
      end
      b_off = {a_off[4:1] ^ nz, r[9]};
      issue(r[10], r[11], RegionBase + 32'(a_off), rand_word(), rand_be(), r[12],
            r[13] | r[14], 1'b0, RegionBase + 32'(b_off));
    end
    wait_responses();
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    a_req_valid_i = 1'b0;
    a_req_write_i = 1'b0;
    a_req_addr_i  = '0;
    a_req_wdata_i = '0;
    a_req_be_i    = '0;
    a_req_wcap_i  = 1'b0;
    a_rsp_ready_i = 1'b1;
    b_req_valid_i = 1'b0;
    b_req_write_i = 1'b0;
    b_req_addr_i  = '0;
    b_rsp_ready_i = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_state();
    test_byte_writes();
    test_cap_tags();
    test_fetch_write();
    test_backpressure();
    test_random_traffic();

    wait_responses();
    if (exp_a.size() != 0 || exp_b.size() != 0) begin
      fail_run("Responses still outstanding at the end of the run");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- sim.f
logic/cap_sram_pkg.sv
logic/mem_port_if.sv
logic/bus_sram_adapter.sv
logic/cap_mem.sv
logic/cap_sram.sv
dv/cap_sram_checker.sv
+incdir+dv
dv/tb_cap_sram.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the tagged SRAM testbench with Verilator and runs it.
# The exit status is the simulator's own status.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_cap_sram -Mdir obj_dir -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_cap_sram
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit "$status"
fi
exit 0
